// ==== Makefile ====
# Verilator build and run of the issue stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_issue
FILELIST  ?= issue.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/issue_clock.sv ====
`timescale 1ns/1ps

module issue_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period.
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== bench/tb_issue.sv ====
`timescale 1ns/1ps

module tb_issue;

  import issue_pkg::*;

  localparam int drain_len   = 10;
  localparam int test_cycles = 1 + 300 + 100 + 600 + 400 + 200 + 3000;
  localparam int watchdog_ns = (5 + test_cycles + 7 * drain_len) * 8 + 1000;

  logic clk, reset, flush, push0, push1, stall, first;
  inst_t instruction0_in, instruction1_in, instruction0_out, instruction1_out;
  addr_t pc0_in, pc1_in, pc0_out, pc1_out;
  inst_id_t id0_in, id1_in, id0_out, id1_out;
  free_count_t free;

  // model queue with slot 0 oldest.
  inst_t    q_inst [queue_depth];
  addr_t    q_pc   [queue_depth];
  inst_id_t q_id   [queue_depth];
  int       q_cnt = 0;

  logic [31:0] rng = 32'h7cda;
  inst_id_t    id_next = '0;
  int error_count = 0, check_count = 0, test_count = 0;
  int pushed = 0, issued = 0, dropped = 0, stall_cycles = 0, dual_cycles = 0;

  opcode_t all_ops  [13] = '{op_nop, op_cmp, op_test, op_cmpi, op_testi, op_lw, op_sw,
                             op_la, op_sa, op_jmp, op_jr, 6'h01, 6'h11};
  opcode_t alu_ops  [3]  = '{6'h01, 6'h11, op_nop};
  opcode_t pipe_ops [9]  = '{op_lw, op_sw, op_la, op_sa, op_jmp, op_jr, op_cmp, op_cmpi, 6'h01};

  issue_clock i_clock (.clk(clk), .reset(reset));

  issue i_dut (
    .clk(clk), .reset(reset), .flush(flush), .push0(push0), .push1(push1),
    .instruction0_in(instruction0_in), .instruction1_in(instruction1_in),
    .pc0_in(pc0_in), .pc1_in(pc1_in), .id0_in(id0_in), .id1_in(id1_in),
    .stall(stall), .free(free), .first(first),
    .instruction0_out(instruction0_out), .instruction1_out(instruction1_out),
    .pc0_out(pc0_out), .pc1_out(pc1_out), .id0_out(id0_out), .id1_out(id1_out)
  );

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic inst_id_t take_id();
    id_next = id_next + 1'b1;
    if (id_next == '0) id_next = 6'd1; // zero marks an empty lane.
    return id_next;
  endfunction

  function automatic inst_t random_inst(input int mode, input logic [4:0] mask);
    logic [31:0] r;
    opcode_t op;
    r = next_random();
    case (mode)
      1, 4: op = alu_ops[r[3:0] % 3];
      3: op = pipe_ops[r[3:0] % 9];
      default: op = all_ops[r[3:0] % 13];
    endcase
    r = next_random();
    return {op, r[25:21] & mask, r[20:16] & mask, r[15:11] & mask, r[10:0]};
  endfunction

  ////////////////////////////////////////
  // reference issue rules

  // {dest, src1, src0}.
  function automatic logic [2:0] uses_of(input inst_t x);
    if (x[31:26] == op_nop) return 3'b000;
    if (x[31:26] == op_jr) return 3'b001;
    if (x[31:30] == 2'b00) return 3'b111;
    if (x[31:30] == 2'b01) return 3'b101;
    if (x[31:26] == op_lw) return 3'b101;
    if (x[31:26] == op_sw) return 3'b011;
    return 3'b000;
  endfunction

  function automatic reg_idx_t dest_of(input inst_t x);
    return (x[31:30] == 2'b00) ? x[15:11] : x[20:16];
  endfunction

  function automatic logic reads_reg(input inst_t r, input logic [2:0] u, input reg_idx_t d);
    return (u[0] && (r[25:21] == d)) || (u[1] && (r[20:16] == d));
  endfunction

  function automatic logic branch_op(input inst_t x);
    return (x[31:30] == 2'b11) && (x[31:26] != op_jmp);
  endfunction

  function automatic logic compare_op(input inst_t x);
    return (x[31:26] == op_cmp) || (x[31:26] == op_test) ||
           (x[31:26] == op_cmpi) || (x[31:26] == op_testi);
  endfunction

  function automatic logic ldst_op(input inst_t x);
    return (x[31:26] == op_lw) || (x[31:26] == op_sw);
  endfunction

  // y is the candidate in slot i, o the older one in slot j.
  function automatic logic conflicts(input inst_t y, input inst_t o, input int i, input int j);
    logic [2:0] uy, uo;
    reg_idx_t dy, dob;
    uy  = uses_of(y);
    uo  = uses_of(o);
    dy  = dest_of(y);
    dob = dest_of(o);
    return (uo[2] && reads_reg(y, uy, dob)) ||
           ((j != 0) && uy[2] && reads_reg(o, uo, dy)) ||
           ((j != 0) && uy[2] && uo[2] && (dy == dob)) ||
           ((j != 0) && branch_op(o)) || ((i > 1) && branch_op(y)) ||
           (branch_op(y) && compare_op(o)) || (branch_op(o) && compare_op(y)) ||
           (ldst_op(y) && ldst_op(o));
  endfunction

  // 0 any, 1 branch, 2 memory.
  function automatic int class_pipe(input inst_t x);
    if (compare_op(x) || (x[31:30] == 2'b11)) return 1;
    if (x[31:30] == 2'b10) return 2;
    return 0;
  endfunction

  function automatic logic ready_slot(input int i);
    for (int j = 0; j < i; j++) begin
      if (conflicts(q_inst[i], q_inst[j], i, j)) return 1'b0;
    end
    return 1'b1;
  endfunction

  ////////////////////////////////////////
  // one cycle of stimulus and checks

  task automatic step(input int mode, input logic [4:0] mask, input int flush_rate);
    int n_push, pick, fill, p0, pk;
    logic exp_first;
    logic [69:0] old_e, young_e, lane0_e, lane1_e;
    @(posedge clk);
    #1;
    case (mode)
      0: n_push = 0;
      4: n_push = 2; // back to back pairs fill the queue.
      default: n_push = int'(next_random() % 3);
    endcase
    if (n_push > queue_depth - q_cnt) n_push = queue_depth - q_cnt;
    push0 = (n_push > 0);
    push1 = (n_push > 1);
    instruction0_in = random_inst(mode, mask);
    instruction1_in = random_inst(mode, mask);
    pc0_in = next_random();
    pc1_in = next_random();
    if (push0) id0_in = take_id();
    if (push1) id1_in = take_id();
    flush = (flush_rate > 0) && ((next_random() % 32'(flush_rate)) == 0);
    #4;
    pick = 0;
    p0 = class_pipe(q_inst[0]);
    for (int i = q_cnt - 1; i >= 1; i--) begin
      pk = class_pipe(q_inst[i]);
      if (ready_slot(i) && !((p0 == pk) && (p0 != 0))) pick = i;
    end
    pk = class_pipe(q_inst[pick]);
    exp_first = (pick > 0) && !flush && (((p0 == 2) && (pk != 2)) || ((p0 == 0) && (pk == 1)));
    old_e   = '0;
    young_e = '0;
    if (!flush && (q_cnt > 0)) old_e = {q_inst[0], q_pc[0], q_id[0]};
    if (!flush && (pick > 0)) young_e = {q_inst[pick], q_pc[pick], q_id[pick]};
    lane0_e = exp_first ? young_e : old_e;
    lane1_e = exp_first ? old_e : young_e;
    check_count++;
    assert ({instruction0_out, pc0_out, id0_out} === lane0_e) else begin
      error_count++;
      $display("** Error at %0t: lane 0 is %h, expected %h", $time,
               {instruction0_out, pc0_out, id0_out}, lane0_e);
    end
    assert ({instruction1_out, pc1_out, id1_out} === lane1_e) else begin
      error_count++;
      $display("** Error at %0t: lane 1 is %h, expected %h", $time,
               {instruction1_out, pc1_out, id1_out}, lane1_e);
    end
    assert ({first, free, stall} === {exp_first, free_count_t'(queue_depth - q_cnt),
                                      q_cnt == queue_depth}) else begin
      error_count++;
      $display("** Error at %0t: first/free/stall %b/%0d/%b, expected %b/%0d/%b", $time,
               first, free, stall, exp_first, queue_depth - q_cnt, q_cnt == queue_depth);
    end
    issued += int'(id0_out != '0) + int'(id1_out != '0);
    if (stall) stall_cycles++;
    pushed += n_push;
    // model state after the coming edge.
    if (flush) begin
      dropped += q_cnt + n_push;
      q_cnt = 0;
    end else begin
      if (pick > 0) dual_cycles++;
      fill = 0;
      for (int k = 1; k < q_cnt; k++) begin
        if (k != pick) begin
          q_inst[fill] = q_inst[k];
          q_pc[fill]   = q_pc[k];
          q_id[fill]   = q_id[k];
          fill++;
        end
      end
      if (push0) begin
        q_inst[fill] = instruction0_in;
        q_pc[fill]   = pc0_in;
        q_id[fill]   = id0_in;
        fill++;
      end
      if (push1) begin
        q_inst[fill] = instruction1_in;
        q_pc[fill]   = pc1_in;
        q_id[fill]   = id1_in;
        fill++;
      end
      q_cnt = fill;
    end
  endtask

  task automatic run_test(input string name, input int cycles, input int mode,
                          input logic [4:0] mask, input int flush_rate);
    int errors_at_start;
    errors_at_start = error_count;
    stall_cycles    = 0;
    dual_cycles     = 0;
    for (int n = 0; n < cycles; n++) step(mode, mask, flush_rate);
    for (int n = 0; n < drain_len; n++) step(0, mask, 0); // let the queue empty.
    assert (pushed == issued + dropped) else begin
      error_count++;
      $display("entries went missing or issued twice: pushed %0d, issued %0d, flushed %0d",
               pushed, issued, dropped);
    end
    test_count++;
    $display("%-8s %0d cycles, %0d dual issue, %0d stalled: %s", name, cycles, dual_cycles,
             stall_cycles, (error_count == errors_at_start) ? "ok" : "errors");
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    flush = 1'b0;
    push0 = 1'b0;
    push1 = 1'b0;
    instruction0_in = '0;
    instruction1_in = '0;
    pc0_in = '0;
    pc1_in = '0;
    id0_in = '0;
    id1_in = '0;
    @(negedge reset);
    run_test("reset", 1, 0, 5'd3, 0);
    run_test("enqueue", 300, 1, 5'd31, 0);
    run_test("fill", 100, 4, 5'd0, 0);
    run_test("hazard", 600, 2, 5'd3, 0);
    run_test("steer", 400, 3, 5'd3, 0);
    run_test("flush", 200, 2, 5'd3, 4);
    run_test("long", 3000, 2, 5'd3, 50);
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hw/issue.sv ====
`timescale 1ns/1ps

module issue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   push0,
  input  logic                   push1,
  input  issue_pkg::inst_t       instruction0_in,
  input  issue_pkg::inst_t       instruction1_in,
  input  issue_pkg::addr_t       pc0_in,
  input  issue_pkg::addr_t       pc1_in,
  input  issue_pkg::inst_id_t    id0_in,
  input  issue_pkg::inst_id_t    id1_in,
  output logic                   stall,
  output issue_pkg::free_count_t free,
  output logic                   first,
  output issue_pkg::inst_t       instruction0_out,
  output issue_pkg::inst_t       instruction1_out,
  output issue_pkg::addr_t       pc0_out,
  output issue_pkg::addr_t       pc1_out,
  output issue_pkg::inst_id_t    id0_out,
  output issue_pkg::inst_id_t    id1_out
);

  import issue_pkg::*;

  slot_mask_t slot_valid;
  slot_mask_t ready;
  inst_t      slot_inst [queue_depth];
  addr_t      slot_pc   [queue_depth];
  inst_id_t   slot_id   [queue_depth];
  reg_idx_t   reg_src0  [queue_depth];
  reg_idx_t   reg_src1  [queue_depth];
  reg_idx_t   reg_dest  [queue_depth];
  reg_use_t   reg_use   [queue_depth];
  logic       pop1;
  slot_idx_t  pop_key1;
  logic       swap;
  inst_t      old_inst, young_inst;
  addr_t      old_pc, young_pc;
  inst_id_t   old_id, young_id;

  issue_queue i_queue (
    .clk(clk), .reset(reset), .flush(flush),
    .push0(push0), .push1(push1),
    .instruction0_in(instruction0_in), .instruction1_in(instruction1_in),
    .pc0_in(pc0_in), .pc1_in(pc1_in), .id0_in(id0_in), .id1_in(id1_in),
    .pop1(pop1), .pop_key1(pop_key1),
    .slot_valid(slot_valid), .slot_inst(slot_inst), .slot_pc(slot_pc),
    .slot_id(slot_id), .free(free)
  );

  for (genvar k = 0; k < queue_depth; k++) begin : g_decode
    reg_decode i_decode (
      .instruction(slot_inst[k]), .reg_src0(reg_src0[k]), .reg_src1(reg_src1[k]),
      .reg_dest(reg_dest[k]), .reg_use(reg_use[k])
    );
  end

  split_hazard i_split (
    .slot_inst(slot_inst), .reg_src0(reg_src0), .reg_src1(reg_src1),
    .reg_dest(reg_dest), .reg_use(reg_use), .slot_valid(slot_valid), .ready(ready)
  );

  steer i_steer (
    .slot_inst(slot_inst), .slot_valid(slot_valid), .ready(ready),
    .pop1(pop1), .pop_key1(pop_key1), .first(swap)
  );

  assign stall = (free == '0);

  ////////////////////////////////////////
  // lane outputs

  always_comb begin
    old_inst   = '0;
    old_pc     = '0;
    old_id     = '0;
    young_inst = '0;
    young_pc   = '0;
    young_id   = '0;
    if (!flush && slot_valid[0]) begin // oldest entry.
      old_inst = slot_inst[0];
      old_pc   = slot_pc[0];
      old_id   = slot_id[0];
    end
    if (!flush && pop1) begin
      young_inst = slot_inst[pop_key1];
      young_pc   = slot_pc[pop_key1];
      young_id   = slot_id[pop_key1];
    end
  end

  assign first = swap & ~flush;

  // older goes to lane 1 when swapped.
  assign instruction0_out = first ? young_inst : old_inst;
  assign instruction1_out = first ? old_inst : young_inst;
  assign pc0_out          = first ? young_pc : old_pc;
  assign pc1_out          = first ? old_pc : young_pc;
  assign id0_out          = first ? young_id : old_id;
  assign id1_out          = first ? old_id : young_id;

endmodule

// ==== hw/issue_pkg.sv ====
package issue_pkg;

  ////////////////////////////////////////
  // sizes and field positions

  localparam int queue_depth = 8;

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;

  typedef logic [31:0] inst_t;
  typedef logic [31:0] addr_t;
  typedef logic [5:0]  inst_id_t;
  typedef logic [opcode_msb-opcode_lsb:0] opcode_t;
  typedef logic [rs_msb-rs_lsb:0] reg_idx_t;
  typedef logic [2:0]  slot_idx_t;
  typedef logic [queue_depth-1:0] slot_mask_t;
  typedef logic [3:0]  free_count_t;
  typedef logic [2:0]  reg_use_t;

  // bits of reg_use_t.
  localparam int use_rs0 = 0;
  localparam int use_rs1 = 1;
  localparam int use_rd  = 2;

  typedef enum logic [1:0] {
    pipe_any,
    pipe_branch,
    pipe_memory
  } pipe_class_t;

  ////////////////////////////////////////
  // opcodes

  localparam opcode_t op_nop   = 6'h00;
  localparam opcode_t op_cmp   = 6'h0e;
  localparam opcode_t op_test  = 6'h0f;
  localparam opcode_t op_cmpi  = 6'h1e;
  localparam opcode_t op_testi = 6'h1f;
  localparam opcode_t op_lw    = 6'h20;
  localparam opcode_t op_sw    = 6'h21;
  localparam opcode_t op_la    = 6'h22;
  localparam opcode_t op_sa    = 6'h23;
  localparam opcode_t op_jmp   = 6'h30;
  localparam opcode_t op_jr    = 6'h31;

  // top two opcode bits.
  localparam logic [1:0] class_reg    = 2'b00;
  localparam logic [1:0] class_imm    = 2'b01;
  localparam logic [1:0] class_mem    = 2'b10;
  localparam logic [1:0] class_branch = 2'b11;

  function automatic opcode_t opcode_of(input inst_t inst);
    return inst[opcode_msb:opcode_lsb];
  endfunction

  function automatic logic [1:0] class_of(input opcode_t op);
    return op[5:4];
  endfunction

  function automatic logic is_compare(input opcode_t op);
    return (op == op_cmp) || (op == op_test) || (op == op_cmpi) || (op == op_testi);
  endfunction

  // jmp has no condition, so it does not count here.
  function automatic logic is_branch(input opcode_t op);
    return (class_of(op) == class_branch) && (op != op_jmp);
  endfunction

endpackage

// ==== hw/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   push0,
  input  logic                   push1,
  input  issue_pkg::inst_t       instruction0_in,
  input  issue_pkg::inst_t       instruction1_in,
  input  issue_pkg::addr_t       pc0_in,
  input  issue_pkg::addr_t       pc1_in,
  input  issue_pkg::inst_id_t    id0_in,
  input  issue_pkg::inst_id_t    id1_in,
  input  logic                   pop1,
  input  issue_pkg::slot_idx_t   pop_key1,
  output issue_pkg::slot_mask_t  slot_valid,
  output issue_pkg::inst_t       slot_inst [issue_pkg::queue_depth],
  output issue_pkg::addr_t       slot_pc   [issue_pkg::queue_depth],
  output issue_pkg::inst_id_t    slot_id   [issue_pkg::queue_depth],
  output issue_pkg::free_count_t free
);

  import issue_pkg::*;

  free_count_t count;
  free_count_t fill;
  inst_t       next_inst [queue_depth];
  addr_t       next_pc   [queue_depth];
  inst_id_t    next_id   [queue_depth];

  always_comb begin
    for (int k = 0; k < queue_depth; k++) begin
      slot_valid[k] = (k < count);
    end
  end

  assign free = free_count_t'(queue_depth) - count;

  ////////////////////////////////////////
  // compaction and append

  always_comb begin
    next_inst = slot_inst;
    next_pc   = slot_pc;
    next_id   = slot_id;
    fill      = '0;
    // slot 0 always leaves when valid.
    for (int k = 1; k < queue_depth; k++) begin
      if (slot_valid[k] && !(pop1 && (pop_key1 == slot_idx_t'(k)))) begin
        next_inst[fill[2:0]] = slot_inst[k];
        next_pc[fill[2:0]]   = slot_pc[k];
        next_id[fill[2:0]]   = slot_id[k];
        fill = fill + 1'b1;
      end
    end
    if (push0) begin
      next_inst[fill[2:0]] = instruction0_in;
      next_pc[fill[2:0]]   = pc0_in;
      next_id[fill[2:0]]   = id0_in;
      fill = fill + 1'b1;
    end
    if (push1 && (fill < queue_depth)) begin // younger of the pair.
      next_inst[fill[2:0]] = instruction1_in;
      next_pc[fill[2:0]]   = pc1_in;
      next_id[fill[2:0]]   = id1_in;
      fill = fill + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      count <= '0;
    end else begin
      count <= fill;
    end
  end

  always_ff @(posedge clk) begin
    slot_inst <= next_inst;
    slot_pc   <= next_pc;
    slot_id   <= next_id;
  end

endmodule

// ==== hw/reg_decode.sv ====
`timescale 1ns/1ps

module reg_decode (
  input  issue_pkg::inst_t    instruction,
  output issue_pkg::reg_idx_t reg_src0,
  output issue_pkg::reg_idx_t reg_src1,
  output issue_pkg::reg_idx_t reg_dest,
  output issue_pkg::reg_use_t reg_use
);

  import issue_pkg::*;

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;

  assign opcode = opcode_of(instruction);
  assign rs     = instruction[rs_msb:rs_lsb];
  assign rt     = instruction[rt_msb:rt_lsb];
  assign rd     = instruction[rd_msb:rd_lsb];

  always_comb begin
    reg_src0 = rs;
    reg_src1 = rt;
    reg_dest = rd;
    reg_use  = '0;
    if (opcode == op_nop) begin
      reg_use = '0;
    end else if (opcode == op_jr) begin
      reg_use[use_rs0] = 1'b1; // jump target.
    end else begin
      case (class_of(opcode))
        class_reg: begin
          reg_use = '1;
        end
        class_imm: begin
          reg_dest         = rt;
          reg_use[use_rs0] = 1'b1;
          reg_use[use_rd]  = 1'b1;
        end
        class_mem: begin
          case (opcode)
            op_lw: begin
              reg_dest         = rt;
              reg_use[use_rs0] = 1'b1;
              reg_use[use_rd]  = 1'b1;
            end
            op_sw: begin
              reg_use[use_rs0] = 1'b1;
              reg_use[use_rs1] = 1'b1;
            end
            default: reg_use = '0; // la and sa have no register fields.
          endcase
        end
        default: reg_use = '0;
      endcase
    end
  end

endmodule

// ==== hw/split_hazard.sv ====
`timescale 1ns/1ps

module split_hazard (
  input  issue_pkg::inst_t      slot_inst [issue_pkg::queue_depth],
  input  issue_pkg::reg_idx_t   reg_src0  [issue_pkg::queue_depth],
  input  issue_pkg::reg_idx_t   reg_src1  [issue_pkg::queue_depth],
  input  issue_pkg::reg_idx_t   reg_dest  [issue_pkg::queue_depth],
  input  issue_pkg::reg_use_t   reg_use   [issue_pkg::queue_depth],
  input  issue_pkg::slot_mask_t slot_valid,
  output issue_pkg::slot_mask_t ready
);

  import issue_pkg::*;

  slot_mask_t branch;
  slot_mask_t compare;
  slot_mask_t load_store;

  // true when the reader uses a source that the writer writes.
  function automatic logic reads_dest(input reg_idx_t src0, input reg_idx_t src1,
                                      input reg_use_t use_r, input reg_idx_t dest,
                                      input reg_use_t use_w);
    return use_w[use_rd] && ((use_r[use_rs0] && (src0 == dest)) ||
                             (use_r[use_rs1] && (src1 == dest)));
  endfunction

  always_comb begin
    for (int k = 0; k < queue_depth; k++) begin
      branch[k]     = is_branch(opcode_of(slot_inst[k]));
      compare[k]    = is_compare(opcode_of(slot_inst[k]));
      load_store[k] = (opcode_of(slot_inst[k]) == op_lw) || (opcode_of(slot_inst[k]) == op_sw);
    end
  end

  ////////////////////////////////////////
  // pairwise check with j older than i

  always_comb begin
    ready = slot_valid;
    for (int i = 1; i < queue_depth; i++) begin
      for (int j = 0; j < i; j++) begin
        if (reads_dest(reg_src0[i], reg_src1[i], reg_use[i], reg_dest[j], reg_use[j]) ||
            ((j != 0) &&
             reads_dest(reg_src0[j], reg_src1[j], reg_use[j], reg_dest[i], reg_use[i])) ||
            ((j != 0) && reg_use[i][use_rd] && reg_use[j][use_rd] &&
             (reg_dest[i] == reg_dest[j])) ||
            ((j != 0) && branch[j]) ||
            ((i > 1) && branch[i]) ||
            (branch[i] && compare[j]) ||
            (compare[i] && branch[j]) ||
            (load_store[i] && load_store[j])) begin
          ready[i] = 1'b0;
        end
      end
    end
  end

endmodule

// ==== hw/steer.sv ====
`timescale 1ns/1ps

module steer (
  input  issue_pkg::inst_t      slot_inst [issue_pkg::queue_depth],
  input  issue_pkg::slot_mask_t slot_valid,
  input  issue_pkg::slot_mask_t ready,
  output logic                  pop1,
  output issue_pkg::slot_idx_t  pop_key1,
  output logic                  first
);

  import issue_pkg::*;

  pipe_class_t pipe [queue_depth];
  slot_mask_t  pair_block;
  slot_mask_t  pair_first;
  slot_mask_t  pick_ok;

  function automatic pipe_class_t pipe_of(input opcode_t op);
    if (is_compare(op) || (class_of(op) == class_branch)) begin
      return pipe_branch;
    end else if (class_of(op) == class_mem) begin
      return pipe_memory;
    end
    return pipe_any;
  endfunction

  always_comb begin
    for (int k = 0; k < queue_depth; k++) begin
      pipe[k] = pipe_of(opcode_of(slot_inst[k]));
    end
  end

  ////////////////////////////////////////
  // pair table against slot 0

  always_comb begin
    pair_block = '0;
    pair_first = '0;
    for (int k = 1; k < queue_depth; k++) begin
      // two branches or two memory ops cannot share the pipes.
      pair_block[k] = (pipe[0] == pipe[k]) && (pipe[0] != pipe_any);
      pair_first[k] = ((pipe[0] == pipe_memory) && (pipe[k] != pipe_memory)) ||
                      ((pipe[0] == pipe_any) && (pipe[k] == pipe_branch));
    end
  end

  assign pick_ok = slot_valid & ready & ~pair_block;

  // lowest eligible slot above 0 wins.
  always_comb begin
    pop1     = 1'b0;
    pop_key1 = '0;
    for (int k = queue_depth - 1; k >= 1; k--) begin
      if (pick_ok[k]) begin
        pop1     = 1'b1;
        pop_key1 = slot_idx_t'(k);
      end
    end
  end

  assign first = pop1 & pair_first[pop_key1];

endmodule

// ==== issue.f ====
hw/issue_pkg.sv
hw/reg_decode.sv
hw/split_hazard.sv
hw/steer.sv
hw/issue_queue.sv
hw/issue.sv
bench/issue_clock.sv
bench/tb_issue.sv
